// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_oh_fifo_async
FLIST = oh_fifo_async.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== include/oh_cfg.svh ====
`ifndef OH_CFG_SVH
`define OH_CFG_SVH

`define CFG_TARGET "GENERIC" // library build target

`endif

// ==== oh_fifo_async.f ====
+incdir+include
verilog/oh_fifo_pkg.sv
verilog/oh_dsync.sv
verilog/oh_memory_dp.sv
verilog/oh_fifo_wptr.sv
verilog/oh_fifo_rptr.sv
verilog/oh_fifo_generic.sv
verilog/oh_fifo_async.sv
test/tb_oh_fifo_async.sv

// ==== test/tb_oh_fifo_async.sv ====
`timescale 1ns/10ps

module tb_oh_fifo_async
  #(parameter int WAIT = 1); // random prog_full wait in the dut

   localparam int DW        = 16;
   localparam int DEPTH     = 16;
   localparam int PROG_FULL = 10;
   localparam int AW        = $clog2(DEPTH);

   // phase lengths in wr_clk cycles
   localparam int RESET_CYC   = 8;
   localparam int FILL_CYC    = 40;
   localparam int MIX_CYC     = 200;
   localparam int DRAIN_CYC   = 40;
   localparam int IDLE_CYC    = 20;
   localparam int TAIL_CYC    = 10;
   localparam int RUN_CYC     = RESET_CYC + FILL_CYC + MIX_CYC + DRAIN_CYC + IDLE_CYC
                                + TAIL_CYC;
   localparam int WATCHDOG_NS = (RUN_CYC + 100) * 100; // 100 cycles of margin

   logic          nreset;
   logic          wr_clk;
   logic          rd_clk;
   logic          wr_en;
   logic          rd_en;
   logic [DW-1:0] din;
   logic [DW-1:0] dout;
   logic          full;
   logic          prog_full;
   logic          empty;
   logic [AW-1:0] rd_count;

   // reference model
   logic [DW-1:0] model_q [$];             // every accepted word in order
   int            n_push = 0;              // accepted writes
   int            n_pop = 0;               // accepted reads
   int            occ;                     // true occupancy
   logic [DW-1:0] exp_dout = '0;           // word due on dout
   logic          dout_due = 1'b0;
   logic          wr_take;                 // write lands on next wr_clk edge
   logic          rd_take;                 // read lands on next rd_clk edge
   logic [2:0]    rd_hist = '0;            // accepted reads over the last three rd edges
   logic [31:0]   low_hist = '0;           // prog_full low over the last 32 wr cycles
   logic          first_cycle;
   logic [31:0]   wr_rng = 32'd23;         // write side xorshift state
   logic [31:0]   rd_rng = 32'd23;         // read side xorshift state
   int            phase;                   // 1 fill, 2 mixed, 3 drain, 4 empty reads

   int            err_reset = 0;
   int            err_data = 0;
   int            err_full = 0;
   int            err_full_early = 0;
   int            err_count = 0;
   int            err_empty = 0;
   int            err_prog = 0;
   int            err_wait = 0;
   int            err_model = 0;
   int            err_end = 0;
   int            total;

   assign occ = n_push - n_pop;

   oh_fifo_async #(.DW(DW), .DEPTH(DEPTH), .WAIT(WAIT), .PROG_FULL(PROG_FULL))
   i_dut (.nreset    (nreset),
          .wr_clk    (wr_clk),
          .wr_en     (wr_en),
          .din       (din),
          .rd_clk    (rd_clk),
          .rd_en     (rd_en),
          .dout      (dout),
          .full      (full),
          .prog_full (prog_full),
          .empty     (empty),
          .rd_count  (rd_count));

   //##########################################################################
   //# helpers
   //##########################################################################
   function automatic logic [31:0] xorshift(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // true in pct of 100 draws
   function automatic bit below(input logic [31:0] r, input int pct);
      return (r % 32'd100) < 32'(pct);
   endfunction

   function automatic int wr_pct(input int ph);
      case (ph)
         1: return 75; // fill until writes hit full
         2: return 50;
         default: return 0;
      endcase
   endfunction

   function automatic int rd_pct(input int ph);
      case (ph)
         2: return 50;
         3: return 80;  // drain
         4: return 100; // reads on empty
         default: return 0;
      endcase
   endfunction

   //##########################################################################
   //# clocks, reset, phases
   //##########################################################################
   initial
   begin
      wr_clk = 1'b0;
      forever #50 wr_clk = ~wr_clk;
   end

   // offset keeps rd edges clear of wr edges
   initial
   begin
      rd_clk = 1'b0;
      #12;
      forever #35 rd_clk = ~rd_clk;
   end

   initial
   begin
      $timeformat(-9, 0, " ns", 0);
      nreset      = 1'b0;
      first_cycle = 1'b0;
      phase       = 0;
      repeat (RESET_CYC) @(posedge wr_clk);
      #5;
      nreset      = 1'b1;
      first_cycle = 1'b1;
      @(posedge wr_clk);
      first_cycle = 1'b0;
      phase       = 1;
      repeat (FILL_CYC) @(posedge wr_clk);
      phase = 2;
      repeat (MIX_CYC) @(posedge wr_clk);
      phase = 3;
      repeat (DRAIN_CYC) @(posedge wr_clk);
      phase = 4;
      repeat (IDLE_CYC) @(posedge wr_clk);
      phase = 0; // quiet tail
      repeat (TAIL_CYC) @(posedge wr_clk);
      @(negedge wr_clk);
      drained: assert (occ == 0 && empty)
         else
         begin
            err_end = err_end + 1;
            $display("fifo not drained at end of run: model holds %0d words, empty = %b",
                     occ, empty);
         end
      total = err_reset + err_data + err_full + err_full_early + err_count + err_empty
              + err_prog + err_wait + err_model + err_end;
      $display("errors: reset %0d data %0d full %0d full_early %0d rd_count %0d empty %0d %s",
               err_reset, err_data, err_full, err_full_early, err_count, err_empty,
               $sformatf("prog_full %0d wait %0d model %0d end %0d total %0d",
                         err_prog, err_wait, err_model, err_end, total));
      if (total == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $finish;
   end

   //##########################################################################
   //# stimulus and model
   //##########################################################################
   // writes go out regardless of full
   initial
   begin
      wr_en   = 1'b0;
      din     = '0;
      wr_take = 1'b0;
      forever
      begin
         @(posedge wr_clk);
         if (wr_take)
         begin
            model_q.push_back(din);
            n_push = n_push + 1;
         end
         #5;
         wr_rng  = xorshift(wr_rng);
         wr_en   = below(wr_rng, wr_pct(phase));
         wr_rng  = xorshift(wr_rng);
         din     = wr_rng[DW-1:0];
         wr_take = wr_en & ~full; // full is steady until the next edge
      end
   end

   initial
   begin
      rd_en   = 1'b0;
      rd_take = 1'b0;
      forever
      begin
         @(posedge rd_clk);
         rd_hist  = {rd_hist[1:0], rd_take};
         dout_due = 1'b0;
         if (rd_take && n_pop < n_push)
         begin
            exp_dout = model_q[n_pop]; // head of the model
            n_pop    = n_pop + 1;
            dout_due = 1'b1;
         end
         else if (rd_take)
         begin
            err_model = err_model + 1;
            $display("read accepted at %0t while the model holds no word", $time);
         end
         #5;
         rd_rng  = xorshift(rd_rng);
         rd_en   = below(rd_rng, rd_pct(phase));
         rd_take = rd_en & ~empty;
      end
   end

   // prog_full low history with one bit per wr cycle
   always @(negedge wr_clk)
   begin
      if (nreset)
         low_hist <= {low_hist[30:0], ~prog_full};
   end

   //##########################################################################
   //# checks on edges where their operands hold still
   //##########################################################################
   reset_state: assert property (@(negedge wr_clk) disable iff (!nreset)
      first_cycle |-> (!full && !prog_full && empty && rd_count == '0))
      else
      begin
         err_reset = err_reset + 1;
         $display("Error at %0t: full/prog_full/empty/rd_count = %b/%b/%b/%0d, %s",
                  $time, full, prog_full, empty, rd_count, "expected 0/0/1/0");
      end

   data_order: assert property (@(negedge rd_clk) disable iff (!nreset)
      dout_due |-> (dout == exp_dout))
      else
      begin
         err_data = err_data + 1;
         $display("Error at %0t: dout = %h, expected %h", $time, dout, exp_dout);
      end

   full_at_depth: assert property (@(negedge wr_clk) disable iff (!nreset)
      (occ == DEPTH) |-> full)
      else
      begin
         err_full = err_full + 1;
         $display("Error at %0t: full = %b, expected 1", $time, full);
      end

   // full may lag reads by up to three rd edges
   full_not_early: assert property (@(negedge wr_clk) disable iff (!nreset)
      full |-> (occ + $countones(rd_hist) >= DEPTH))
      else
      begin
         err_full_early = err_full_early + 1;
         $display("Error at %0t: full = 1, expected 0 (model holds %0d, %0d recent reads)",
                  $time, occ, $countones(rd_hist));
      end

   rd_count_bound: assert property (@(negedge rd_clk) disable iff (!nreset)
      int'(rd_count) <= occ)
      else
      begin
         err_count = err_count + 1;
         $display("Error at %0t: rd_count = %0d, expected at most %0d",
                  $time, rd_count, occ);
      end

   empty_when_drained: assert property (@(negedge rd_clk) disable iff (!nreset)
      (occ == 0) |-> empty)
      else
      begin
         err_empty = err_empty + 1;
         $display("Error at %0t: empty = %b, expected 1", $time, empty);
      end

   prog_full_level: assert property (@(negedge wr_clk) disable iff (!nreset)
      (occ >= PROG_FULL) |-> prog_full)
      else
      begin
         err_prog = err_prog + 1;
         $display("Error at %0t: prog_full = %b, expected 1 (model holds %0d)",
                  $time, prog_full, occ);
      end

   wait_window: assert property (@(posedge wr_clk) disable iff (!nreset)
      (WAIT == 0) || ($countones(low_hist) <= 1))
      else
      begin
         err_wait = err_wait + 1;
         $display("prog_full was low in %0d of the last 32 wr_clk cycles at %0t",
                  $countones(low_hist), $time);
      end

endmodule

// ==== verilog/oh_dsync.sv ====
`timescale 1ns/10ps

// two flop synchronizer for a gray pointer word
// only one bit moves per pointer step, so a late sample
// lands on either the old or the new value, never between
module oh_dsync
  (input  logic               nreset, // async reset
   input  logic               clk,    // destination clock
   input  oh_fifo_pkg::ptr_t  din,    // pointer from the source domain
   output oh_fifo_pkg::ptr_t  dout    // pointer in the destination domain
   );

   oh_fifo_pkg::ptr_t sync_meta; // first stage, may go metastable

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         sync_meta <= '0;
         dout      <= '0;
      end
      else
      begin
         sync_meta <= din;       // capture
         dout      <= sync_meta; // settle
      end
   end

endmodule

// ==== verilog/oh_fifo_async.sv ====
`timescale 1ns/10ps
`include "oh_cfg.svh"

// dual clock fifo, library top level
// target selection plus an optional random prog_full wait source
module oh_fifo_async
  #(parameter int DW        = 104,           // fifo width
    parameter int DEPTH     = 32,            // fifo depth, power of two
    parameter     TARGET    = `CFG_TARGET,   // only "GENERIC" is built
    parameter int WAIT      = 0,             // random prog_full wait on
    parameter int PROG_FULL = DEPTH/2,       // prog_full threshold
    localparam int AW       = $clog2(DEPTH)) // count width
   (input  logic          nreset,    // async reset
    // write port
    input  logic          wr_clk,    // write clock
    input  logic          wr_en,     // write fifo
    input  logic [DW-1:0] din,       // data to write
    // read port
    input  logic          rd_clk,    // read clock
    input  logic          rd_en,     // read fifo
    output logic [DW-1:0] dout,      // output data, next cycle
    // status
    output logic          full,      // fifo is full
    output logic          prog_full, // threshold reached or wait active
    output logic          empty,     // fifo is empty
    output logic [AW-1:0] rd_count   // valid entries, read side view
    );

   oh_fifo_pkg::wr_flags_t fifo_flags; // flags from the core
   logic                   wait_random;

   assign full      = fifo_flags.full;
   assign prog_full = fifo_flags.prog_full | wait_random; // upstream backs off

   //##########################################################################
   //# fifo core
   //##########################################################################
   generate
      if (TARGET == "GENERIC")
      begin : g_generic
         oh_fifo_generic #(.DW(DW), .DEPTH(DEPTH), .PROG_FULL(PROG_FULL))
         i_fifo (.nreset   (nreset),
                 .wr_clk   (wr_clk),
                 .rd_clk   (rd_clk),
                 .wr_en    (wr_en),
                 .rd_en    (rd_en),
                 .din      (din),
                 .dout     (dout),
                 .wr_flags (fifo_flags),
                 .empty    (empty),
                 .rd_count (rd_count),
                 .wr_count ());          // writer count not exported
      end
      else
      begin : g_bad_target
         $fatal(1, "oh_fifo_async: unsupported TARGET %s", TARGET);
      end
   endgenerate

   //##########################################################################
   //# random wait generator
   //##########################################################################
   generate
      if (WAIT > 0)
      begin : g_wait
         logic [7:0] wait_counter; // free running on wr_clk

         always_ff @(posedge wr_clk or negedge nreset)
         begin
            if (!nreset)
               wait_counter <= '0;
            else
               wait_counter <= wait_counter + 8'd1;
         end

         // low one cycle in 32
         assign wait_random = |wait_counter[4:0];
      end
      else
      begin : g_no_wait
         assign wait_random = 1'b0;
      end
   endgenerate

endmodule

// ==== verilog/oh_fifo_generic.sv ====
`timescale 1ns/10ps

// portable dual clock fifo
// memory + pointer blocks + gray pointer synchronizers
module oh_fifo_generic
  #(parameter int DW        = 104,           // data width
    parameter int DEPTH     = 32,            // number of entries
    parameter int PROG_FULL = DEPTH/2,       // prog_full threshold
    localparam int AW       = $clog2(DEPTH)) // address width
   (input  logic                   nreset,   // async reset
    input  logic                   wr_clk,   // write clock
    input  logic                   rd_clk,   // read clock
    input  logic                   wr_en,    // write fifo
    input  logic                   rd_en,    // read fifo
    input  logic [DW-1:0]          din,      // write data
    output logic [DW-1:0]          dout,     // read data, next cycle
    output oh_fifo_pkg::wr_flags_t wr_flags, // full and prog_full
    output logic                   empty,    // fifo is empty
    output logic [AW-1:0]          rd_count, // entries seen by reader
    output logic [AW-1:0]          wr_count  // entries seen by writer
    );

   oh_fifo_pkg::ptr_t wr_gray;      // write pointer, wr_clk
   oh_fifo_pkg::ptr_t wr_gray_sync; // write pointer, rd_clk
   oh_fifo_pkg::ptr_t rd_gray;      // read pointer, rd_clk
   oh_fifo_pkg::ptr_t rd_gray_sync; // read pointer, wr_clk
   logic [AW-1:0]     wr_addr;
   logic [AW-1:0]     rd_addr;
   logic              mem_wr;
   logic              mem_rd;

   //##########################################################################
   //# storage
   //##########################################################################
   oh_memory_dp #(.DW(DW), .DEPTH(DEPTH))
   i_mem (.wr_clk(wr_clk), .mem_wr(mem_wr), .wr_addr(wr_addr), .din(din),
          .rd_clk(rd_clk), .mem_rd(mem_rd), .rd_addr(rd_addr), .dout(dout));

   //##########################################################################
   //# write domain
   //##########################################################################
   oh_fifo_wptr #(.DEPTH(DEPTH), .PROG_FULL(PROG_FULL))
   i_wptr (.nreset       (nreset),
           .wr_clk       (wr_clk),
           .wr_en        (wr_en),
           .rd_gray_sync (rd_gray_sync),
           .wr_gray      (wr_gray),
           .wr_addr      (wr_addr),
           .mem_wr       (mem_wr),
           .wr_flags     (wr_flags),
           .wr_count     (wr_count));

   // read pointer into wr_clk
   oh_dsync i_rd_sync (.nreset(nreset), .clk(wr_clk), .din(rd_gray), .dout(rd_gray_sync));

   //##########################################################################
   //# read domain
   //##########################################################################
   oh_fifo_rptr #(.DEPTH(DEPTH))
   i_rptr (.nreset       (nreset),
           .rd_clk       (rd_clk),
           .rd_en        (rd_en),
           .wr_gray_sync (wr_gray_sync),
           .rd_gray      (rd_gray),
           .rd_addr      (rd_addr),
           .mem_rd       (mem_rd),
           .empty        (empty),
           .rd_count     (rd_count));

   // write pointer into rd_clk
   oh_dsync i_wr_sync (.nreset(nreset), .clk(rd_clk), .din(wr_gray), .dout(wr_gray_sync));

endmodule

// ==== verilog/oh_fifo_pkg.sv ====
package oh_fifo_pkg;

   // widest pointer: 16 address bits plus the wrap bit
   localparam int PTR_MAX = 17;

   typedef logic [PTR_MAX-1:0] ptr_t; // binary or gray pointer word

   // write side status, travels from wptr up to the top
   typedef struct packed {
      logic full;      // no free entry
      logic prog_full; // occupancy at or above threshold
   } wr_flags_t;

   // binary to gray
   function automatic ptr_t bin2gray(input ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

   // gray to binary, msb first
   function automatic ptr_t gray2bin(input ptr_t gray);
      ptr_t bin;
      bin[PTR_MAX-1] = gray[PTR_MAX-1];
      for (int i = PTR_MAX-2; i >= 0; i--)
      begin
         bin[i] = bin[i+1] ^ gray[i]; // running xor from the top
      end
      return bin;
   endfunction

endpackage

// ==== verilog/oh_fifo_rptr.sv ====
`timescale 1ns/10ps

// read side pointer logic
// keeps binary and gray read pointers, derives empty and rd_count
module oh_fifo_rptr
  #(parameter int DEPTH = 32,             // number of entries
    localparam int AW   = $clog2(DEPTH))  // address width
   (input  logic              nreset,       // async reset
    input  logic              rd_clk,       // read clock
    input  logic              rd_en,        // read request
    input  oh_fifo_pkg::ptr_t wr_gray_sync, // write pointer, gray, in rd_clk
    output oh_fifo_pkg::ptr_t rd_gray,      // read pointer, gray
    output logic [AW-1:0]     rd_addr,      // memory read address
    output logic              mem_rd,       // memory read enable
    output logic              empty,        // nothing to read
    output logic [AW-1:0]     rd_count      // entries readable, pessimistic
    );

   // keeps the pointer inside AW+1 bits
   localparam oh_fifo_pkg::ptr_t PTR_MASK = (oh_fifo_pkg::ptr_t'(1) << (AW+1)) - 1;

   oh_fifo_pkg::ptr_t rd_bin;      // binary read pointer
   oh_fifo_pkg::ptr_t rd_bin_next; // pointer after this cycle
   oh_fifo_pkg::ptr_t wr_bin_sync; // decoded write pointer
   oh_fifo_pkg::ptr_t avail;       // readable entries incl. wrap bit

   //##########################################################################
   //# pointer
   //##########################################################################
   assign mem_rd      = rd_en & ~empty; // reads on empty are ignored
   assign rd_bin_next = (rd_bin + oh_fifo_pkg::ptr_t'(mem_rd)) & PTR_MASK;

   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end
      else
      begin
         rd_bin  <= rd_bin_next;
         rd_gray <= oh_fifo_pkg::bin2gray(rd_bin_next);
      end
   end

   assign rd_addr = rd_bin[AW-1:0]; // address of the current head word

   //##########################################################################
   //# empty and count
   //##########################################################################
   // equal gray words, write side has caught nothing new
   assign empty = (rd_gray == wr_gray_sync);

   // synced write pointer lags, so the count never reads high
   assign wr_bin_sync = oh_fifo_pkg::gray2bin(wr_gray_sync);
   assign avail       = (wr_bin_sync - rd_bin) & PTR_MASK;
   assign rd_count    = avail[AW-1:0];

endmodule

// ==== verilog/oh_fifo_wptr.sv ====
`timescale 1ns/10ps

// write side pointer logic
// keeps binary and gray write pointers, derives full / prog_full
module oh_fifo_wptr
  #(parameter int DEPTH     = 32,            // number of entries
    parameter int PROG_FULL = DEPTH/2,       // prog_full threshold
    localparam int AW       = $clog2(DEPTH)) // address width
   (input  logic                   nreset,       // async reset
    input  logic                   wr_clk,       // write clock
    input  logic                   wr_en,        // write request
    input  oh_fifo_pkg::ptr_t      rd_gray_sync, // read pointer, gray, in wr_clk
    output oh_fifo_pkg::ptr_t      wr_gray,      // write pointer, gray
    output logic [AW-1:0]          wr_addr,      // memory write address
    output logic                   mem_wr,       // memory write enable
    output oh_fifo_pkg::wr_flags_t wr_flags,     // full and prog_full
    output logic [AW-1:0]          wr_count      // entries in use, pessimistic
    );

   // keeps the pointer inside AW+1 bits
   localparam oh_fifo_pkg::ptr_t PTR_MASK = (oh_fifo_pkg::ptr_t'(1) << (AW+1)) - 1;
   // full when the gray words differ in exactly the top two bits
   localparam oh_fifo_pkg::ptr_t TOP_MASK = oh_fifo_pkg::ptr_t'(3) << (AW-1);

   oh_fifo_pkg::ptr_t wr_bin;      // binary write pointer
   oh_fifo_pkg::ptr_t wr_bin_next; // pointer after this cycle
   oh_fifo_pkg::ptr_t rd_bin_sync; // decoded read pointer
   oh_fifo_pkg::ptr_t fill;        // occupancy incl. the wrap bit

   //##########################################################################
   //# pointer
   //##########################################################################
   assign mem_wr      = wr_en & ~wr_flags.full; // drop writes while full
   assign wr_bin_next = (wr_bin + oh_fifo_pkg::ptr_t'(mem_wr)) & PTR_MASK;

   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end
      else
      begin
         wr_bin  <= wr_bin_next;
         wr_gray <= oh_fifo_pkg::bin2gray(wr_bin_next); // registered, glitch free
      end
   end

   assign wr_addr = wr_bin[AW-1:0]; // wrap bit dropped

   //##########################################################################
   //# count and flags
   //##########################################################################
   // synced read pointer lags, so fill never reads low
   assign rd_bin_sync = oh_fifo_pkg::gray2bin(rd_gray_sync);
   assign fill        = (wr_bin - rd_bin_sync) & PTR_MASK;
   assign wr_count    = fill[AW-1:0];

   // both flags follow the registered pointer, same cycle as the write
   assign wr_flags.full      = ((wr_gray ^ rd_gray_sync) == TOP_MASK);
   assign wr_flags.prog_full = (fill >= oh_fifo_pkg::ptr_t'(PROG_FULL));

endmodule

// ==== verilog/oh_memory_dp.sv ====
`timescale 1ns/10ps

// simple dual port ram
// write port on wr_clk, registered read port on rd_clk
module oh_memory_dp
  #(parameter int DW    = 104,            // word width
    parameter int DEPTH = 32,             // number of words
    localparam int AW   = $clog2(DEPTH))  // address width
   (// write port
    input  logic          wr_clk,  // write clock
    input  logic          mem_wr,  // write enable
    input  logic [AW-1:0] wr_addr, // write address
    input  logic [DW-1:0] din,     // write data
    // read port
    input  logic          rd_clk,  // read clock
    input  logic          mem_rd,  // read enable
    input  logic [AW-1:0] rd_addr, // read address
    output logic [DW-1:0] dout     // read data, next cycle
    );

   logic [DW-1:0] ram [DEPTH]; // storage array

   //##########################################################################
   //# write side
   //##########################################################################
   always_ff @(posedge wr_clk)
   begin
      if (mem_wr)
         ram[wr_addr] <= din;
   end

   //##########################################################################
   //# read side
   //##########################################################################
   // dout only moves on a read, holds between reads
   always_ff @(posedge rd_clk)
   begin
      if (mem_rd)
         dout <= ram[rd_addr];
   end

endmodule
